// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

  // Data, address and instruction word
  typedef logic [31:0] word_t;

  // Register number in rs, rt or rd fields
  typedef logic [4:0] reg_idx_t;

  // Primary opcodes in bits 31:26
  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_t;

  // Funct codes for special opcode, bits 5:0
  typedef enum logic [5:0] {
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_slt  = 6'h2a
  } funct_t;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // Write-back source
  typedef enum logic {
    wb_alu,
    wb_mem
  } wb_sel_t;

  // Boot ROM address
  localparam word_t reset_vector_c = 32'hBFC00000;

endpackage

`default_nettype wire

// File: ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
  import mips_pkg::*;

  // Register write and destination select
  logic    reg_write;
  logic    reg_dst_rd;
  // ALU operand B and operation
  logic    alu_src_imm;
  alu_op_t alu_op;
  // Write-back and data port strobes
  wb_sel_t wb_sel;
  logic    mem_read;
  logic    mem_write;
  // Flow control
  logic    branch_eq;
  logic    branch_ne;
  logic    jump;
  logic    jump_reg;

  modport source (
    output reg_write, reg_dst_rd, alu_src_imm, alu_op, wb_sel,
    output mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg
  );

  modport sink (
    input reg_write, reg_dst_rd, alu_src_imm, alu_op, wb_sel,
    input mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg
  );

endinterface

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  mips_pkg::word_t instr,
  input  logic            active,
  output logic            illegal,
  ctrl_if.source          ctrl
);
  import mips_pkg::*;

  opcode_t opcode;
  funct_t  funct;
  logic    recognised;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  // Only flagged while the core runs
  assign illegal = active && !recognised;

  always_comb
  begin
    // Everything idle unless decode says otherwise
    ctrl.reg_write   = 1'b0;
    ctrl.reg_dst_rd  = 1'b0;
    ctrl.alu_src_imm = 1'b0;
    ctrl.alu_op      = alu_add;
    ctrl.wb_sel      = wb_alu;
    ctrl.mem_read    = 1'b0;
    ctrl.mem_write   = 1'b0;
    ctrl.branch_eq   = 1'b0;
    ctrl.branch_ne   = 1'b0;
    ctrl.jump        = 1'b0;
    ctrl.jump_reg    = 1'b0;
    recognised       = 1'b1;
    if (active)
    begin
      case (opcode)
        op_special:
        begin
          // R-type writes rd, except JR
          ctrl.reg_write  = (funct != fn_jr);
          ctrl.reg_dst_rd = 1'b1;
          case (funct)
            fn_addu: ctrl.alu_op = alu_add;
            fn_subu: ctrl.alu_op = alu_sub;
            fn_and:  ctrl.alu_op = alu_and;
            fn_or:   ctrl.alu_op = alu_or;
            fn_slt:  ctrl.alu_op = alu_slt;
            fn_jr:   ctrl.jump_reg = 1'b1;
            default:
            begin
              // Unknown funct, drop the write again
              ctrl.reg_write = 1'b0;
              recognised     = 1'b0;
            end
          endcase
        end
        op_addiu:
        begin
          ctrl.reg_write   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
        end
        op_lw:
        begin
          ctrl.reg_write   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.wb_sel      = wb_mem;
          ctrl.mem_read    = 1'b1;
        end
        op_sw:
        begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write   = 1'b1;
        end
        // Branches compare by subtraction
        op_beq:
        begin
          ctrl.alu_op    = alu_sub;
          ctrl.branch_eq = 1'b1;
        end
        op_bne:
        begin
          ctrl.alu_op    = alu_sub;
          ctrl.branch_ne = 1'b1;
        end
        op_j:    ctrl.jump = 1'b1;
        default: recognised = 1'b0;
      endcase
    end
  end

  // At most one flow-control request per instruction
  always_comb
  begin
    assert ($onehot0({ctrl.jump, ctrl.jump_reg, ctrl.branch_eq, ctrl.branch_ne}));
  end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  logic              clk_enable,
  input  mips_pkg::reg_idx_t rs_idx,
  input  mips_pkg::reg_idx_t rt_idx,
  input  mips_pkg::reg_idx_t wr_idx,
  input  mips_pkg::word_t    wr_data,
  ctrl_if.sink               ctrl,
  output mips_pkg::word_t    rs_data,
  output mips_pkg::word_t    rt_data,
  output mips_pkg::word_t    v0
);
  import mips_pkg::*;

  word_t regs [32];

  // Write port, register 0 never written
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (clk_enable && ctrl.reg_write && (wr_idx != 5'd0))
    begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Combinational reads, zero register hard-wired
  assign rs_data = (rs_idx == 5'd0) ? '0 : regs[rs_idx];
  assign rt_data = (rt_idx == 5'd0) ? '0 : regs[rt_idx];

  // $v0 for the top-level port
  assign v0 = regs[2];

  // Storage behind $zero must never pick up a value
  assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  mips_pkg::word_t rs_data,
  input  mips_pkg::word_t rt_data,
  input  logic [15:0]     imm,
  ctrl_if.sink            ctrl,
  output mips_pkg::word_t result,
  output logic            zero
);
  import mips_pkg::*;

  word_t imm_ext;
  word_t op_b;

  // Sign-extended immediate for ADDIU, LW, SW
  assign imm_ext = {{16{imm[15]}}, imm};

  // Operand B mux
  assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb
  begin
    case (ctrl.alu_op)
      alu_add: result = rs_data + op_b;
      alu_sub: result = rs_data - op_b;
      alu_and: result = rs_data & op_b;
      alu_or:  result = rs_data | op_b;
      // Signed compare gives 0 or 1
      alu_slt: result = {31'd0, $signed(rs_data) < $signed(op_b)};
      default: result = '0;
    endcase
  end

  // Equal operands under SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc #(
  parameter mips_pkg::word_t reset_vector = mips_pkg::reset_vector_c
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  input  mips_pkg::word_t instr,
  input  mips_pkg::word_t rs_data,
  input  logic            zero,
  ctrl_if.sink            ctrl,
  output mips_pkg::word_t pc
);
  import mips_pkg::*;

  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;
  word_t target;
  logic  taken;
  // Target waiting for the delay slot to finish
  word_t pending_target;
  logic  pending;

  assign pc_plus4 = pc + 32'd4;

  // Relative to the delay-slot address
  assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  // Region of the delay slot plus 26-bit index
  assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

  assign taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero) ||
                 ctrl.jump || ctrl.jump_reg;

  always_comb
  begin
    if (ctrl.jump_reg)
      target = rs_data;
    else if (ctrl.jump)
      target = jump_target;
    else
      target = branch_target;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= reset_vector;
      pending <= 1'b0;
    end
    // PC of 0 means halted, hold it
    else if (clk_enable && (pc != '0))
    begin
      pc      <= pending ? pending_target : pc_plus4;
      pending <= taken;
    end
  end

  // Target captured while the branch or jump executes
  always_ff @(posedge clk)
  begin
    if (clk_enable && taken)
    begin
      pending_target <= target;
    end
  end

  // Fetches are word aligned
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: mips_cpu_harvard.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard #(
  parameter mips_pkg::word_t reset_vector = mips_pkg::reset_vector_c
) (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  // Instruction port, combinational read
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  // Data port, combinational read, write at the enabled edge
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  import mips_pkg::*;

  word_t    rs_data;
  word_t    rt_data;
  word_t    v0;
  word_t    alu_result;
  word_t    wr_data;
  word_t    pc;
  reg_idx_t wr_idx;
  logic     zero;
  logic     run;

  ctrl_if ctrl ();

  // Nothing executes from address 0, that is the halt point
  assign run = active && (pc != '0);

  control_unit i_control_unit (
    .instr   (instr_readdata),
    .active  (run),
    .illegal (),
    .ctrl    (ctrl)
  );

  // Destination is rd for R-type, rt otherwise
  assign wr_idx = ctrl.reg_dst_rd ? instr_readdata[15:11] : instr_readdata[20:16];

  // Loads write memory data, everything else the ALU result
  assign wr_data = (ctrl.wb_sel == wb_mem) ? data_readdata : alu_result;

  register_file i_register_file (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .rs_idx     (instr_readdata[25:21]),
    .rt_idx     (instr_readdata[20:16]),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .ctrl       (ctrl),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .v0         (v0)
  );

  alu i_alu (
    .rs_data (rs_data),
    .rt_data (rt_data),
    .imm     (instr_readdata[15:0]),
    .ctrl    (ctrl),
    .result  (alu_result),
    .zero    (zero)
  );

  next_pc #(
    .reset_vector (reset_vector)
  ) i_next_pc (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .instr      (instr_readdata),
    .rs_data    (rs_data),
    .zero       (zero),
    .ctrl       (ctrl),
    .pc         (pc)
  );

  // Active flag, drops once the PC has reached 0
  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b1;
    else if (clk_enable && (pc == '0))
      active <= 1'b0;
  end

  assign instr_address  = pc;
  assign register_v0    = v0;

  // Base plus offset from the ALU, store data from rt
  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_read      = ctrl.mem_read;
  assign data_write     = ctrl.mem_write;

endmodule

`default_nettype wire

// File: tb_mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;

  // Cycle budget for one program to reach the halt
  localparam int timeout_cycles = 2000;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  // Word-wide memories, 1 KB window each
  logic [31:0] imem [256];
  logic [31:0] dmem [256];

  // Records of the current test
  logic [31:0]     iaddr_q [$];
  logic [31:0]     iword_q [$];
  logic [31:0]     daddr_q [$];
  logic [31:0]     dword_q [$];
  logic [31:0]     maddr_q [$];
  logic [31:0]     mword_q [$];
  logic [31:0]     expected_v0;
  logic [8*24-1:0] test_name;
  logic            random_mode;
  int              tests_run;

  mips_cpu_harvard i_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  // Combinational reads, word index from address bits 9:2
  assign instr_readdata = imem[instr_address[9:2]];
  assign data_readdata  = dmem[data_address[9:2]];

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %0s: expected %08h, got %08h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic reject_record(input logic [7:0] kind);
    $display("Malformed or unknown record %c in cpu_test_input.txt", kind);
    $display("FAIL: see errors above");
    $fatal(1, "bad input record");
  endtask

  // About one frozen cycle in four in random mode
  function automatic logic next_enable();
    if (random_mode)
      return ($urandom % 4) != 0;
    return 1'b1;
  endfunction

  task automatic load_memories();
    logic [31:0] a;
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    foreach (iaddr_q[i])
    begin
      a = iaddr_q[i];
      imem[a[9:2]] = iword_q[i];
    end
    foreach (daddr_q[i])
    begin
      a = daddr_q[i];
      dmem[a[9:2]] = dword_q[i];
    end
  endtask

  // Called at a falling edge, returns at the next one
  task automatic step_cycle();
    logic        commit;
    logic [7:0]  idx;
    logic [31:0] wdata;
    // Data port is settled here
    commit = clk_enable && data_write;
    idx    = data_address[9:2];
    wdata  = data_writedata;
    @(posedge clk);
    // Store lands at the enabled edge only
    if (commit)
      dmem[idx] = wdata;
    clk_enable <= next_enable();
    @(negedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset      <= 1'b1;
    clk_enable <= 1'b1;
    repeat (5) @(posedge clk);
    reset      <= 1'b0;
    clk_enable <= next_enable();
    @(negedge clk);
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (active === 1'b1 && cycles < timeout_cycles)
    begin
      step_cycle();
      cycles++;
    end
    if (active !== 1'b0)
    begin
      $display("Timeout: test %0s still active after %0d cycles", test_name,
               timeout_cycles);
      $display("FAIL: see errors above");
      $fatal(1, "halt timeout");
    end
  endtask

  task automatic run_program(input logic random_enable);
    logic [31:0] a;
    random_mode = random_enable;
    load_memories();
    apply_reset();
    wait_for_halt();
    // State at halt
    check_value("register_v0", expected_v0, register_v0);
    foreach (maddr_q[i])
    begin
      a = maddr_q[i];
      check_value($sformatf("dmem[%08h]", a), mword_q[i], dmem[a[9:2]]);
    end
    // PC parked at 0, core idle
    repeat (3) step_cycle();
    check_value("instr_address", 32'h0, instr_address);
    check_value("active", 32'h0, {31'd0, active});
    check_value("data_write", 32'h0, {31'd0, data_write});
    check_value("data_read", 32'h0, {31'd0, data_read});
    $display("Test %0s done, random clk_enable %0d", test_name, random_mode);
  endtask

  // Test sequencer, driven by the input file
  initial
  begin
    int          fd;
    int          n;
    int          c;
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] w;
    reset      <= 1'b1;
    clk_enable <= 1'b1;
    random_mode = 1'b0;
    tests_run   = 0;
    expected_v0 = '0;
    test_name   = '0;
    void'($urandom(32'hffa8));
    load_memories();
    fd = $fopen("cpu_test_input.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open cpu_test_input.txt");
      $display("FAIL: see errors above");
      $fatal(1, "missing input file");
    end
    while ($fscanf(fd, "%s", tag) == 1)
    begin
      case (tag)
        "#":
        begin
          // Skip rest of comment line
          c = $fgetc(fd);
          while (c != 10 && c != -1)
            c = $fgetc(fd);
        end
        "T":
        begin
          n = $fscanf(fd, "%s", test_name);
          if (n != 1)
            reject_record(tag);
          iaddr_q.delete();
          iword_q.delete();
          daddr_q.delete();
          dword_q.delete();
          maddr_q.delete();
          mword_q.delete();
          expected_v0 = '0;
        end
        "I", "D", "M":
        begin
          n = $fscanf(fd, "%h %h", a, w);
          if (n != 2)
            reject_record(tag);
          case (tag)
            "I":
            begin
              iaddr_q.push_back(a);
              iword_q.push_back(w);
            end
            "D":
            begin
              daddr_q.push_back(a);
              dword_q.push_back(w);
            end
            default:
            begin
              maddr_q.push_back(a);
              mword_q.push_back(w);
            end
          endcase
        end
        "E":
        begin
          n = $fscanf(fd, "%h", expected_v0);
          if (n != 1)
            reject_record(tag);
        end
        "G":
        begin
          // Steady enable first, then the random pattern
          run_program(1'b0);
          run_program(1'b1);
          tests_run++;
        end
        default: reject_record(tag);
      endcase
    end
    $fclose(fd);
    if (tests_run == 0)
    begin
      $display("No test was run, the input file holds no G record");
      $display("FAIL: see errors above");
      $fatal(1, "empty test file");
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: cpu_test_input.txt
# Records: T name | I addr instr | D addr data | E expected v0
# M addr expected data word | G runs the test, all values in hex
# ALU ops, SLT sign, writes to $zero, JR delay slot
T arith
I bfc00000 24080005
I bfc00004 2409fffd
I bfc00008 01091021
I bfc0000c 01095023
I bfc00010 01485825
I bfc00014 01696024
I bfc00018 0128682a
I bfc0001c 24000007
I bfc00020 004c1021
I bfc00024 004d1021
I bfc00028 004a1023
I bfc0002c 00401021
I bfc00030 0109702a
I bfc00034 004e1021
I bfc00038 00000008
I bfc0003c 24420100
I bfc00040 24420001
E 00000108
G
# Loads and stores with positive and negative offsets
T memory
I bfc00000 24080100
I bfc00004 8d090000
I bfc00008 25290001
I bfc0000c ad090004
I bfc00010 8d020004
I bfc00014 ad02fffc
I bfc00018 8d0afffc
I bfc0001c 01481021
I bfc00020 00000008
I bfc00024 00000021
D 00000100 12345678
E 12345779
M 00000100 12345678
M 00000104 12345679
M 000000fc 12345679
G
# Taken and not-taken BEQ and BNE, one bit of v0 per path
T branch
I bfc00000 24080003
I bfc00004 24090003
I bfc00008 11090003
I bfc0000c 24420001
I bfc00010 24420010
I bfc00014 24420020
I bfc00018 1509000a
I bfc0001c 24420100
I bfc00020 24420200
I bfc00024 15000003
I bfc00028 24421000
I bfc0002c 24422000
I bfc00030 24424000
I bfc00034 11000003
I bfc00038 24420400
I bfc0003c 00000008
I bfc00040 24420800
I bfc00044 24420002
E 00001f01
G
# J forward and back, JR through a loaded address
T jump
I bfc00000 0bf00008
I bfc00004 24420001
I bfc00008 24420004
I bfc0000c 24420008
I bfc00010 00000008
I bfc00014 24420020
I bfc00018 24420040
I bfc00020 8c080000
I bfc00024 01000008
I bfc00028 24420100
I bfc0002c 24420200
I bfc00040 24421000
I bfc00044 0bf00004
I bfc00048 24422000
I bfc0004c 24424000
D 00000000 bfc00040
E 00003121
G

// File: sim.f
mips_pkg.sv
ctrl_if.sv
control_unit.sv
register_file.sv
alu.sv
next_pc.sv
mips_cpu_harvard.sv
tb_mips_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
